//--- hdl/spi_seq_pkg.sv
`default_nettype none

package spi_seq_pkg;

   localparam int IMEM_AW     = 9;             // 512 instruction bytes
   localparam int DMEM_AW     = 7;             // 128 result words
   localparam int CMD_W       = 32;            // SPI frame and command width
   localparam int CMD_BYTES   = CMD_W / 8;     // Command bytes behind the options byte
   localparam int SEL_W       = 4;             // One-hot target mask width
   localparam int SLEEP_SHIFT = 4;             // Sleep unit is 2**SLEEP_SHIFT cycles
   localparam int SCLK_DIV    = 2;             // clk cycles per sclk half period

   // Options byte, bits 7:6 reserved
   localparam int OPT_RNW_BIT = 0;             // Frame returns data
   localparam int OPT_SEL_LSB = 1;             // Target mask in bits 4:1
   localparam int OPT_END_BIT = 5;             // Last instruction of the pass

   typedef enum logic [2:0] {
      FETCH_OPT,                               // Present options byte address
      FETCH_CMD,                               // Collect options and command bytes
      ISSUE,                                   // Staged, waiting for an idle master
      WAIT_IDLE,                               // END frame in flight
      SLEEP                                    // Idle time between passes
   } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/spi_host_pkg.sv
`default_nettype none

package spi_host_pkg;

   localparam int WB_AW    = 11;               // Bus word address width
   localparam int REGION_W = 2;                // Upper address bits picking the window

   // CTRL register layout
   localparam int CTRL_EN_BIT    = 0;          // Engine enable
   localparam int CTRL_SLEEP_LSB = 8;          // Sleep byte in bits 15:8

   // Windows by wb_adr[10:9]
   // 00 CTRL, 01 RESULT, 1x IMEM
   typedef enum logic [1:0] {
      REGION_CTRL,                             // Control register
      REGION_RESULT,                           // Result memory, read only
      REGION_IMEM                              // Instruction memory, write only
   } host_region_t;

endpackage

`default_nettype wire

//--- hdl/spi_dpram.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port RAM, write on A and registered read on B
module spi_dpram #(
   parameter int AW = 9,                       // Address width
   parameter int DW = 8                        // Data width
) (
   input  wire           clk,
   input  wire           wa_en,                // Port A write strobe
   input  wire  [AW-1:0] wa_addr,
   input  wire  [DW-1:0] wa_data,
   input  wire  [AW-1:0] rb_addr,              // Port B read address
   output logic [DW-1:0] rb_data               // Valid one cycle after rb_addr
);

   logic [DW-1:0] mem [0:(1 << AW) - 1];       // Storage, no reset

   always_ff @(posedge clk) begin
      if (wa_en) begin
         mem[wa_addr] <= wa_data;              // Synchronous write
      end
   end

   // Read returns old data on a same-address write
   always_ff @(posedge clk) begin
      rb_data <= mem[rb_addr];
   end

endmodule

`default_nettype wire

//--- hdl/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

// Mode 0 SPI master, one fixed CMD_W bit frame per start
module spi_master import spi_seq_pkg::*; (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              start,            // Accepted only while idle
   input  wire  [CMD_W-1:0] cmd,
   input  wire  [SEL_W-1:0] sel,              // One-hot target
   input  wire              rnw,
   input  wire              miso,
   output logic             busy,
   output logic             rvalid,           // Last cycle of a read frame
   output logic [CMD_W-1:0] rdata,
   output logic             sclk,
   output logic             mosi,
   output logic [SEL_W-1:0] cs_n
);

   localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
   localparam int BIT_W = $clog2(CMD_W);

   logic [DIV_W-1:0] div_cnt;                  // Half period counter
   logic [BIT_W-1:0] bit_cnt;                  // Bits completed
   logic [CMD_W-1:0] tx_sr;                    // Outgoing bits, MSB on mosi
   logic [CMD_W-1:0] rx_sr;                    // Sampled miso bits
   logic             rnw_q;
   logic             tick;                     // sclk edge due this cycle
   logic             last_edge;                // Final falling edge

   assign tick      = busy && (div_cnt == DIV_W'(SCLK_DIV - 1));
   assign last_edge = tick && sclk && (bit_cnt == BIT_W'(CMD_W - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         sclk    <= 1'b0;
         cs_n    <= '1;
         div_cnt <= '0;
         bit_cnt <= '0;
         tx_sr   <= '0;
         rnw_q   <= 1'b0;
      end else if (!busy) begin
         if (start) begin
            busy    <= 1'b1;
            cs_n    <= ~sel;                   // Held for the whole frame
            tx_sr   <= cmd;                    // MSB on mosi before first rise
            rnw_q   <= rnw;
            div_cnt <= '0;
            bit_cnt <= '0;
         end
      end else begin
         div_cnt <= tick ? '0 : div_cnt + 1'b1;
         if (tick) begin
            if (!sclk) begin
               sclk <= 1'b1;                   // Rising edge, target samples
            end else if (last_edge) begin
               busy <= 1'b0;                   // Frame done
               sclk <= 1'b0;
               cs_n <= '1;
            end else begin
               sclk    <= 1'b0;                // Falling edge, next bit out
               tx_sr   <= tx_sr << 1;
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   // miso capture on the rising edge
   always_ff @(posedge clk) begin
      if (tick && !sclk) begin
         rx_sr <= {rx_sr[CMD_W-2:0], miso};
      end
   end

   assign mosi   = tx_sr[CMD_W-1];
   assign rdata  = rx_sr;
   assign rvalid = last_edge && rnw_q;         // Last miso bit already in

endmodule

`default_nettype wire

//--- hdl/spi_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sequencer import spi_seq_pkg::*; (
   input  wire                clk,
   input  wire                rst_n,
   input  wire                en,             // Engine enable from CTRL
   input  wire  [7:0]         sleep,          // Sleep in units of 2**SLEEP_SHIFT
   input  wire  [7:0]         imem_data,      // Byte from imem, one cycle late
   input  wire                spi_busy,
   input  wire                spi_rvalid,
   input  wire  [CMD_W-1:0]   spi_rdata,
   output logic [IMEM_AW-1:0] imem_addr,
   output logic               spi_start,
   output logic [CMD_W-1:0]   spi_cmd,
   output logic [SEL_W-1:0]   spi_sel,
   output logic               spi_rnw,
   output logic               dmem_we,
   output logic [DMEM_AW-1:0] dmem_addr,
   output logic [CMD_W-1:0]   dmem_wdata
);

   seq_state_t                 state;
   logic [2:0]                 byte_cnt;       // Index of the byte arriving on imem_data
   logic [7+SLEEP_SHIFT:0]     sleep_cnt;      // Down counter for the gap between passes
   logic [DMEM_AW-1:0]         res_ptr;        // Next result slot
   logic [CMD_W-1:0]           cmd_q;          // Staged command
   logic [SEL_W-1:0]           opt_sel;        // Staged target mask
   logic                       opt_rnw;        // Staged read flag
   logic                       opt_end;        // Staged END flag
   logic                       pass_restart;   // Sleep done, new pass begins

   assign pass_restart = (state == SLEEP) && (sleep_cnt == '0);

   // Master must be idle, the latched slot then moves into it
   assign spi_start = en && (state == ISSUE) && !spi_busy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= FETCH_OPT;
         imem_addr <= '0;
         byte_cnt  <= '0;
         sleep_cnt <= '0;
      end else if (!en) begin
         state     <= FETCH_OPT;               // Abort, restart stream at 0
         imem_addr <= '0;
         byte_cnt  <= '0;
      end else begin
         case (state)
            FETCH_OPT: begin
               imem_addr <= imem_addr + 1'b1;  // First command byte next
               byte_cnt  <= '0;
               state     <= FETCH_CMD;
            end
            FETCH_CMD: begin
               byte_cnt <= byte_cnt + 1'b1;
               if (byte_cnt != 3'(CMD_BYTES)) begin
                  imem_addr <= imem_addr + 1'b1; // Ends on next options byte
               end else begin
                  state <= ISSUE;              // Last command byte landing now
               end
            end
            ISSUE: begin
               if (spi_start) begin
                  state <= opt_end ? WAIT_IDLE : FETCH_OPT; // Prefetch unless END
               end
            end
            WAIT_IDLE: begin
               if (!spi_busy) begin
                  sleep_cnt <= {sleep, {SLEEP_SHIFT{1'b1}}}; // (sleep+1) units minus one
                  state     <= SLEEP;
               end
            end
            SLEEP: begin
               if (pass_restart) begin
                  imem_addr <= '0;
                  state     <= FETCH_OPT;
               end else begin
                  sleep_cnt <= sleep_cnt - 1'b1;
               end
            end
            default: state <= FETCH_OPT;
         endcase
      end
   end

   // Instruction assembly, byte 0 is options and 1..4 the command MSB first
   always_ff @(posedge clk) begin
      if (state == FETCH_CMD) begin
         if (byte_cnt == '0) begin
            opt_rnw <= imem_data[OPT_RNW_BIT];
            opt_sel <= imem_data[OPT_SEL_LSB +: SEL_W];
            opt_end <= imem_data[OPT_END_BIT];
         end else begin
            cmd_q <= {cmd_q[CMD_W-9:0], imem_data};
         end
      end
   end

   assign spi_cmd = cmd_q;
   assign spi_sel = opt_sel;
   assign spi_rnw = opt_rnw;

   // Result pointer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_ptr <= '0;
      end else if (!en || pass_restart) begin
         res_ptr <= '0;                        // Each pass starts at slot 0
      end else if (dmem_we) begin
         res_ptr <= res_ptr + 1'b1;
      end
   end

   assign dmem_we    = spi_rvalid && en;       // Frames finishing after disable are dropped
   assign dmem_addr  = res_ptr;
   assign dmem_wdata = spi_rdata;

endmodule

`default_nettype wire

//--- hdl/spi_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic slave with CTRL register and memory windows
module spi_wb_regs import spi_host_pkg::*, spi_seq_pkg::*; (
   input  wire                clk,
   input  wire                rst_n,
   input  wire                wb_cyc,
   input  wire                wb_stb,
   input  wire                wb_we,
   input  wire  [WB_AW-1:0]   wb_adr,
   input  wire  [31:0]        wb_dat_w,
   input  wire  [CMD_W-1:0]   dmem_rdata,     // Result RAM port B
   output logic [31:0]        wb_dat_r,
   output logic               wb_ack,
   output logic               en,
   output logic [7:0]         sleep,
   output logic               imem_we,
   output logic [IMEM_AW-1:0] imem_waddr,
   output logic [7:0]         imem_wdata,
   output logic [DMEM_AW-1:0] dmem_raddr
);

   host_region_t region;
   logic         req;                          // New request this cycle
   logic         wr;                           // New write this cycle
   logic [31:0]  ctrl_word;

   // Held request already acked in the previous cycle does not count again
   assign req = wb_cyc && wb_stb && !wb_ack;
   assign wr  = req && wb_we;

   always_comb begin
      case (wb_adr[WB_AW-1 -: REGION_W])
         2'b00:   region = REGION_CTRL;
         2'b01:   region = REGION_RESULT;
         default: region = REGION_IMEM;
      endcase
   end

   // Single cycle ack, matches result RAM read latency
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= req;
      end
   end

   // CTRL register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         en    <= 1'b0;
         sleep <= '0;
      end else if (wr && (region == REGION_CTRL)) begin
         en    <= wb_dat_w[CTRL_EN_BIT];
         sleep <= wb_dat_w[CTRL_SLEEP_LSB +: 8];
      end
   end

   always_comb begin
      ctrl_word                       = '0;
      ctrl_word[CTRL_EN_BIT]          = en;
      ctrl_word[CTRL_SLEEP_LSB +: 8]  = sleep;
   end

   // Instruction memory writes, one byte per bus word
   assign imem_we    = wr && (region == REGION_IMEM);
   assign imem_waddr = wb_adr[IMEM_AW-1:0];
   assign imem_wdata = wb_dat_w[7:0];

   // Address held by the master until ack, data lands with ack
   assign dmem_raddr = wb_adr[DMEM_AW-1:0];

   always_comb begin
      case (region)
         REGION_CTRL:   wb_dat_r = ctrl_word;
         REGION_RESULT: wb_dat_r = dmem_rdata;
         default:       wb_dat_r = '0;  // IMEM is write only
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/spi_mon_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_mon_top import spi_host_pkg::*, spi_seq_pkg::*; (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              wb_cyc,
   input  wire              wb_stb,
   input  wire              wb_we,
   input  wire  [WB_AW-1:0] wb_adr,
   input  wire  [31:0]      wb_dat_w,
   output logic [31:0]      wb_dat_r,
   output logic             wb_ack,
   output logic             sclk,
   output logic             mosi,
   input  wire              miso,
   output logic [SEL_W-1:0] cs_n
);

   logic               en;                     // CTRL to sequencer
   logic [7:0]         sleep;
   logic               imem_we;                // Host writes to imem
   logic [IMEM_AW-1:0] imem_waddr;
   logic [7:0]         imem_wdata;
   logic [IMEM_AW-1:0] imem_addr;              // Sequencer fetch
   logic [7:0]         imem_data;
   logic               dmem_we;                // Sequencer result store
   logic [DMEM_AW-1:0] dmem_addr;
   logic [CMD_W-1:0]   dmem_wdata;
   logic [DMEM_AW-1:0] dmem_raddr;             // Host result read
   logic [CMD_W-1:0]   dmem_rdata;
   logic               spi_start;              // Sequencer to master
   logic [CMD_W-1:0]   spi_cmd;
   logic [SEL_W-1:0]   spi_sel;
   logic               spi_rnw;
   logic               spi_busy;
   logic               spi_rvalid;
   logic [CMD_W-1:0]   spi_rdata;

   spi_wb_regs wb_regs_i (
      .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .dmem_rdata,
      .wb_dat_r, .wb_ack, .en, .sleep, .imem_we, .imem_waddr, .imem_wdata, .dmem_raddr
   );

   spi_dpram #(.AW(IMEM_AW), .DW(8)) imem_ram (
      .clk, .wa_en(imem_we), .wa_addr(imem_waddr), .wa_data(imem_wdata),
      .rb_addr(imem_addr), .rb_data(imem_data)
   );

   spi_dpram #(.AW(DMEM_AW), .DW(CMD_W)) dmem_ram (
      .clk, .wa_en(dmem_we), .wa_addr(dmem_addr), .wa_data(dmem_wdata),
      .rb_addr(dmem_raddr), .rb_data(dmem_rdata)
   );

   spi_sequencer sequencer_i (
      .clk, .rst_n, .en, .sleep, .imem_data, .spi_busy, .spi_rvalid, .spi_rdata,
      .imem_addr, .spi_start, .spi_cmd, .spi_sel, .spi_rnw, .dmem_we, .dmem_addr, .dmem_wdata
   );

   spi_master master_i (
      .clk, .rst_n, .start(spi_start), .cmd(spi_cmd), .sel(spi_sel), .rnw(spi_rnw), .miso,
      .busy(spi_busy), .rvalid(spi_rvalid), .rdata(spi_rdata), .sclk, .mosi, .cs_n
   );

endmodule

`default_nettype wire

//--- sim/spi_mon_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Bus and SPI pin rules, bound into spi_mon_top
module spi_mon_checker (
   input wire       clk,
   input wire       rst_n,
   input wire       wb_cyc,
   input wire       wb_stb,
   input wire       wb_ack,
   input wire       sclk,
   input wire [3:0] cs_n
);

   int fail_cnt = 0;                           // Failed assertions so far

   ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> (wb_cyc && wb_stb))
      else begin
         fail_cnt++;
         $error("wb_ack raised without cyc and stb");
      end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
      else begin
         fail_cnt++;
         $error("wb_ack held longer than one cycle");
      end

   // One target at a time
   cs_one_low: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(~cs_n))
      else begin
         fail_cnt++;
         $error("more than one cs_n low");
      end

   sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
      (cs_n == 4'hf) |-> !sclk)
      else begin
         fail_cnt++;
         $error("sclk high with no target selected");
      end

endmodule

`default_nettype wire

//--- sim/spi_mon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_mon_tb;

   localparam logic [10:0] CTRL_ADR    = 11'h000;
   localparam logic [10:0] RESULT_ADR  = 11'h200;   // Result words by index
   localparam logic [10:0] IMEM_ADR    = 11'h400;   // One instruction byte per bus word
   localparam logic [31:0] TARGET_BASE = 32'hc0de_0000; // Reply of target k is base plus k

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic        wb_cyc = 1'b0;
   logic        wb_stb = 1'b0;
   logic        wb_we = 1'b0;
   logic [10:0] wb_adr = '0;
   logic [31:0] wb_dat_w = '0;
   logic        miso = 1'b0;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic        sclk;
   logic        mosi;
   logic [3:0]  cs_n;

   // Expected program, frames repeat with period prog_len
   logic [31:0] prog_cmd [20];
   logic [3:0]  prog_sel [20];                      // One-hot target mask
   logic        prog_rnw [20];
   int          prog_len = 0;
   int          prog_base = 0;                      // frame_cnt when the program was loaded
   int          frame_cnt = 0;
   int          errors = 0;
   int          timeouts = 0;
   string       test_name = "reset";
   logic [31:0] rd;
   int          n;
   int          rd_idx;

   logic [31:0] tgt_sr = '0;                        // Target reply shifter
   logic [3:0]  tgt_cs_prev = 4'hf;
   logic        tgt_sclk_prev = 1'b0;
   logic [31:0] frm_cmd = '0;                       // Rebuilt mosi frame
   logic [3:0]  frm_cs = 4'hf;
   int          frm_bits = 0;
   logic [3:0]  mon_cs_prev = 4'hf;
   logic        mon_sclk_prev = 1'b0;

   spi_mon_top spi_mon_top_i (
      .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
      .sclk, .mosi, .miso, .cs_n
   );

   bind spi_mon_top spi_mon_checker mon_checker_i (
      .clk, .rst_n, .wb_cyc, .wb_stb, .wb_ack, .sclk, .cs_n
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] target_word(input int k);
      return TARGET_BASE + 32'(k);
   endfunction

   function automatic int sel_index(input logic [3:0] mask);
      for (int k = 0; k < 4; k++) begin
         if (mask[k]) return k;
      end
      return 0;
   endfunction

   task automatic finish_run();
      int chk_fails;
      chk_fails = spi_mon_top_i.mon_checker_i.fail_cnt;
      $display("Errors: %0d value, %0d timeout, %0d protocol", errors, timeouts, chk_fails);
      if (errors == 0 && timeouts == 0 && chk_fails == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   endtask

   task automatic abort_run(input string why);
      timeouts++;
      $display("Timeout in %s: %s", test_name, why);
      finish_run();
   endtask

   task automatic check_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      assert (act_v === exp_v) else begin
         errors++;
         $display("ERR %s %s expected %h actual %h", test_name, what, exp_v, act_v);
      end
   endtask

   // Classic cycle, held until the edge that samples ack
   task automatic bus_cycle(input logic we, input logic [10:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      int cyc_n;
      @(posedge clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      cyc_n    = 0;
      do begin
         @(posedge clk);
         #1;
         cyc_n++;
      end while (!wb_ack && cyc_n < 16);
      if (!wb_ack) begin
         abort_run("no ack from the Wishbone slave");
      end else begin
         check_value("ack latency", 32'd1, 32'(cyc_n));
         rdata = wb_dat_r;
         @(posedge clk);
         #1;
         wb_cyc = 1'b0;
         wb_stb = 1'b0;
         wb_we  = 1'b0;
      end
   endtask

   task automatic write_word(input logic [10:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic read_word(input logic [10:0] adr, output logic [31:0] data);
      bus_cycle(1'b0, adr, 32'h0, data);
   endtask

   task automatic wait_frames(input int target, input int limit);
      int cnt;
      cnt = 0;
      while (frame_cnt < target && cnt < limit) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      if (frame_cnt < target) abort_run("expected SPI frames did not arrive");
   endtask

   task automatic wait_cs(input logic active, input int limit);
      int cnt;
      cnt = 0;
      while ((cs_n != 4'hf) != active && cnt < limit) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      if ((cs_n != 4'hf) != active) abort_run("cs_n did not change as expected");
   endtask

   task automatic expect_quiet(input int cycles);
      int bad;
      bad = 0;
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk);
         #1;
         if (cs_n != 4'hf || sclk) bad++;
      end
      assert (bad == 0) else begin
         errors++;
         $display("SPI pins active in %0d cycles of a quiet window in %s", bad, test_name);
      end
   endtask

   // Options byte is {2'b00, end, sel[3:0], rnw}, then the command MSB first
   task automatic load_program();
      logic [7:0] opt;
      prog_base = frame_cnt;
      for (int i = 0; i < prog_len; i++) begin
         opt = {2'b00, (i == prog_len - 1), prog_sel[i], prog_rnw[i]};
         write_word(IMEM_ADR + 11'(5 * i), {24'h0, opt});
         for (int b = 0; b < 4; b++) begin
            write_word(IMEM_ADR + 11'(5 * i + 1 + b), {24'h0, prog_cmd[i][31 - 8 * b -: 8]});
         end
      end
   endtask

   task automatic check_frame();
      int idx;
      if (prog_len == 0) begin
         errors++;
         $display("Frame on cs_n %b while no program was loaded", frm_cs);
      end else begin
         idx = (frame_cnt - prog_base) % prog_len;
         check_value("frame cs_n", {28'h0, ~prog_sel[idx]}, {28'h0, frm_cs});
         check_value("frame command", prog_cmd[idx], frm_cmd);
         check_value("frame bits", 32'd32, 32'(frm_bits));
      end
      frame_cnt++;
   endtask

   // Target model, reply shifts on falling sclk
   always @(posedge clk) begin
      #1;
      if (cs_n == 4'hf) begin
         tgt_sr = '0;
      end else if (tgt_cs_prev == 4'hf) begin
         tgt_sr = target_word(sel_index(~cs_n)); // New frame
      end else if (tgt_sclk_prev && !sclk) begin
         tgt_sr = tgt_sr << 1;
      end
      miso          = tgt_sr[31];
      tgt_cs_prev   = cs_n;
      tgt_sclk_prev = sclk;
   end

   // Frame monitor, mid-cycle so pins are settled
   always @(negedge clk) begin
      if (cs_n != 4'hf && mon_cs_prev == 4'hf) begin
         frm_cs   = cs_n;
         frm_bits = 0;
      end
      if (cs_n != 4'hf && !mon_sclk_prev && sclk) begin
         frm_cmd = {frm_cmd[30:0], mosi};        // Bit on rising sclk
         frm_bits++;
      end
      if (cs_n == 4'hf && mon_cs_prev != 4'hf) check_frame();
      mon_cs_prev   = cs_n;
      mon_sclk_prev = sclk;
   end

   initial begin
      void'($urandom(32'hdf28_bf8c));
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      check_value("cs_n", 32'hf, {28'h0, cs_n});
      check_value("sclk", 32'h0, {31'h0, sclk});
      check_value("ack", 32'h0, {31'h0, wb_ack});
      read_word(CTRL_ADR, rd);
      check_value("ctrl", 32'h0, rd);
      expect_quiet(300);                          // en still 0

      test_name   = "three_frames";
      prog_len    = 3;
      prog_cmd[0] = 32'h0212_3456;                 // Write to target 0
      prog_sel[0] = 4'b0001;
      prog_rnw[0] = 1'b0;
      prog_cmd[1] = 32'h8300_00a5;                 // Read target 1
      prog_sel[1] = 4'b0010;
      prog_rnw[1] = 1'b1;
      prog_cmd[2] = 32'h8400_5a00;                 // Read target 2, END
      prog_sel[2] = 4'b0100;
      prog_rnw[2] = 1'b1;
      load_program();
      write_word(CTRL_ADR, {16'h0, 8'd3, 8'h01});
      wait_frames(prog_base + 3, 2000);

      test_name = "first_results";
      read_word(RESULT_ADR, rd);
      check_value("result 0", target_word(1), rd);
      read_word(RESULT_ADR + 11'd1, rd);
      check_value("result 1", target_word(2), rd);

      test_name = "second_pass";
      wait_frames(prog_base + 6, 2000);
      read_word(RESULT_ADR, rd);
      check_value("result 0", target_word(1), rd);
      read_word(RESULT_ADR + 11'd1, rd);
      check_value("result 1", target_word(2), rd);
      read_word(RESULT_ADR + 11'd2, rd);           // Slot 2 only fills if the pointer runs on
      assert (rd !== target_word(1)) else begin
         errors++;
         $display("ERR %s result 2 expected not %h actual %h", test_name, target_word(1), rd);
      end

      test_name = "disable";
      wait_cs(1'b1, 600);                          // Frame in flight
      n = frame_cnt;
      write_word(CTRL_ADR, {16'h0, 8'd3, 8'h00});
      wait_cs(1'b0, 600);
      expect_quiet(500);
      check_value("frames after disable", 32'(n + 1), 32'(frame_cnt));

      test_name = "random_program";
      prog_len  = 1 + int'($urandom % 20);
      for (int i = 0; i < prog_len; i++) begin
         prog_cmd[i] = $urandom;
         prog_sel[i] = 4'b0001 << ($urandom % 4);
         prog_rnw[i] = 1'($urandom % 2);
      end
      load_program();
      write_word(CTRL_ADR, {16'h0, 8'($urandom % 4), 8'h01});
      wait_frames(prog_base + 2 * prog_len, 300 * prog_len + 1000);
      rd_idx = 0;
      for (int i = 0; i < prog_len; i++) begin
         if (prog_rnw[i]) begin
            read_word(RESULT_ADR + 11'(rd_idx), rd);
            check_value($sformatf("result %0d", rd_idx), target_word(sel_index(prog_sel[i])), rd);
            rd_idx++;
         end
      end
      finish_run();
   end

endmodule

`default_nettype wire

//--- vlog.f
hdl/spi_seq_pkg.sv
hdl/spi_host_pkg.sv
hdl/spi_dpram.sv
hdl/spi_master.sv
hdl/spi_sequencer.sv
hdl/spi_wb_regs.sv
hdl/spi_mon_top.sv
sim/spi_mon_checker.sv
sim/spi_mon_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the spi_mon testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spi_mon_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
out=$(./obj_dir/Vspi_mon_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
   exit 0
fi
exit 1
